// File: project.f
hdl/sampler_pkg.sv
hdl/sampler_piso.sv
hdl/rej_sampler.sv
hdl/exp_mask.sv
hdl/sampler_ctrl.sv
hdl/sampler_top.sv
tests/tb_clkgen.sv
tests/sampler_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= sampler_tb
RTL_TOP   ?= sampler_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/sampler_tb.sv
// Testbench for the coefficient sampler
//   stimulus table of runs applied in a loop
//   Fibonacci LFSR word source with optional valid gaps
//   bit-stream model for rejection sampling and mask expansion
//   compare task, error count and watchdog
`timescale 1ns/1ps
`default_nettype none

module sampler_tb
  import sampler_pkg::*;
();

  localparam int N           = 256;
  localparam int GROUPS      = N / COEFF_PER_CLK;
  localparam int NUM_ROWS    = 8;
  localparam int WDOG_CYCLES = NUM_ROWS * GROUPS * 16 + 500;

  // mode, base address, valid gaps, zeroize after k groups, groups expected
  typedef struct packed {
    sampler_mode_e     mode;
    logic [ADDR_W-1:0] base;
    logic              gaps;
    logic [7:0]        zero_k;
    logic [7:0]        exp_grps;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{SAMPLER_REJ, 8'h00, 1'b0, 8'd0, 8'd64},
    '{SAMPLER_EXP, 8'h10, 1'b0, 8'd0, 8'd64},
    '{SAMPLER_REJ, 8'h00, 1'b1, 8'd0, 8'd64},
    '{SAMPLER_EXP, 8'hd0, 1'b1, 8'd0, 8'd64},
    '{SAMPLER_REJ, 8'h00, 1'b0, 8'd5, 8'd5},
    '{SAMPLER_EXP, 8'h20, 1'b1, 8'd9, 8'd9},
    '{SAMPLER_REJ, 8'h00, 1'b1, 8'd0, 8'd64},
    '{SAMPLER_EXP, 8'h00, 1'b0, 8'd0, 8'd64}
  };

  logic              clk;
  logic              rst_b;
  logic              zeroize;
  sampler_mode_e     mode;
  logic              start;
  logic [ADDR_W-1:0] base_addr;
  logic              rand_valid;
  rand_word_t        rand_data;
  logic              rand_hold;
  logic              busy;
  coeff_out_t        ntt;
  mem_wr_t           mem;

  logic [31:0]       lfsr;
  int                err_cnt;
  int                chk_cnt;
  logic              xfer_pending;
  logic              stalled;
  rand_word_t        sent_words[$];
  coeff_grp_t        got_grps[$];
  logic [ADDR_W-1:0] got_addrs[$];
  coeff_t            exp_coeffs[$];

  tb_clkgen #(.PERIOD(20), .RST_CYCLES(5)) clkgen_i (.clk_o(clk), .rst_b_o(rst_b));

  sampler_top #(.N(N), .ADDR_W(ADDR_W)) dut_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize),
    .sampler_mode_i   (mode),
    .sampler_start_i  (start),
    .dest_base_addr_i (base_addr),
    .rand_valid_i     (rand_valid),
    .rand_data_i      (rand_data),
    .rand_hold_o      (rand_hold),
    .busy_o           (busy),
    .ntt_o            (ntt),
    .mem_o            (mem)
  );

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic rand_word_t take_bits(input int n);
    rand_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[31];
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    end
    return v;
  endfunction

  // word source driven on the falling edge
  task automatic drive_source(input logic gaps);
    rand_word_t w;
    if (xfer_pending) begin
      sent_words.push_back(rand_data);
      rand_data = take_bits(64);
    end
    // a held word stays offered
    if (!stalled) begin
      if (gaps) begin
        w = take_bits(1);
        rand_valid = w[0];
      end else begin
        rand_valid = 1'b1;
      end
    end
  endtask

  // expected coefficients from the words that were actually transferred
  task automatic build_model(input sampler_mode_e m, input int n_coeffs);
    logic bits[$];
    int   width;
    int   pos;
    int   r;
    int   v;
    exp_coeffs.delete();
    foreach (sent_words[w]) begin
      for (int b = 0; b < RAND_W; b++) bits.push_back(sent_words[w][b]);
    end
    width = (m == SAMPLER_REJ) ? REJ_SAMPLE_W : EXP_SAMPLE_W;
    pos = 0;
    while ((exp_coeffs.size() < n_coeffs) && (pos + width <= bits.size())) begin
      r = 0;
      for (int b = 0; b < width; b++) r = r | (int'(bits[pos + b]) << b);
      pos = pos + width;
      if (m == SAMPLER_REJ) begin
        v = r & ((1 << Q_WIDTH) - 1);
        if (v < int'(MLDSA_Q)) exp_coeffs.push_back(coeff_t'(v));
      end else begin
        v = GAMMA1 - r;
        if (v < 0) v = v + int'(MLDSA_Q);
        exp_coeffs.push_back(coeff_t'(v));
      end
    end
  endtask

  task automatic run_row(input row_t row);
    int   cycle;
    int   last_grp_cycle;
    logic first;
    logic zero_done;
    logic done;
    sent_words.delete();
    got_grps.delete();
    got_addrs.delete();
    xfer_pending = 1'b0;
    stalled = 1'b0;
    rand_valid = 1'b0;
    cycle = 0;
    last_grp_cycle = 0;
    first = 1'b1;
    zero_done = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      start = first;
      mode = row.mode;
      if (first) base_addr = row.base;
      zeroize = (row.zero_k != 0) && !zero_done && (got_grps.size() == int'(row.zero_k));
      drive_source(row.gaps);
      #1;
      xfer_pending = rand_valid && !rand_hold;
      stalled = rand_valid && rand_hold;
      if (first) begin
        check_value(128'(busy), 128'(1'b1), "busy_o in the start cycle");
      end else if (zero_done) begin
        check_value(128'(busy), 128'(1'b0), "busy_o after zeroize");
        check_value(128'(rand_hold), 128'(1'b1), "rand_hold_o after zeroize");
        done = 1'b1;
      end else if (!busy) begin
        check_value(128'(cycle - last_grp_cycle), 128'(2), "cycles from last group to idle");
        done = 1'b1;
      end
      if (zeroize) zero_done = 1'b1;
      if (row.mode == SAMPLER_REJ) begin
        check_value(128'(mem.dv), 128'(1'b0), "mem_o.dv in rejection mode");
        if (ntt.dv) begin
          got_grps.push_back(ntt.data);
          last_grp_cycle = cycle;
        end
      end else begin
        check_value(128'(ntt.dv), 128'(1'b0), "ntt_o.dv in mask mode");
        if (mem.dv) begin
          got_grps.push_back(mem.data);
          got_addrs.push_back(mem.addr);
          last_grp_cycle = cycle;
        end
      end
      first = 1'b0;
      cycle++;
    end
    start = 1'b0;
    zeroize = 1'b0;
  endtask

  task automatic compare_groups(input row_t row);
    int                n_grp;
    coeff_grp_t        exp_grp;
    logic [ADDR_W-1:0] exp_addr;
    n_grp = int'(row.exp_grps);
    check_value(128'(got_grps.size()), 128'(n_grp), "number of groups");
    build_model(row.mode, n_grp * COEFF_PER_CLK);
    if (exp_coeffs.size() < n_grp * COEFF_PER_CLK) begin
      err_cnt++;
      $display("The model ran out of stream bits before the expected groups were complete");
    end
    for (int g = 0; (g < n_grp) && (g < got_grps.size()); g++) begin
      for (int i = 0; i < COEFF_PER_CLK; i++) begin
        exp_grp[i] = exp_coeffs[g * COEFF_PER_CLK + i];
      end
      check_value(128'(got_grps[g]), 128'(exp_grp), $sformatf("group %0d data", g));
      if (row.mode == SAMPLER_EXP) begin
        exp_addr = row.base + ADDR_W'(g);
        check_value(128'(got_addrs[g]), 128'(exp_addr), $sformatf("group %0d address", g));
      end
    end
  endtask

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the runs did not complete", WDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
    zeroize = 1'b0;
    mode = SAMPLER_REJ;
    start = 1'b0;
    base_addr = '0;
    rand_valid = 1'b0;
    rand_data = '0;
    xfer_pending = 1'b0;
    stalled = 1'b0;
    lfsr = 32'h0c668243;
    rand_data = take_bits(64);
    wait (rst_b === 1'b1);
    @(negedge clk);
    #1;
    check_value(128'(busy), 128'(1'b0), "busy_o after reset");
    check_value(128'(rand_hold), 128'(1'b1), "rand_hold_o after reset");
    check_value(128'(ntt.dv), 128'(1'b0), "ntt_o.dv after reset");
    check_value(128'(mem.dv), 128'(1'b0), "mem_o.dv after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(ROWS[r]);
      compare_groups(ROWS[r]);
    end
    $display("sampler_tb finished with %0d errors in %0d checks", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
// Testbench clock and reset source
//   free-running clock, 20 ns period
//   active-low reset held for a number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_b_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge
  initial begin
    rst_b_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_b_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/sampler_top.sv
// Coefficient sampler top level
//   run control, bit-stream buffer, rejection sampler, mask expansion
//   NTT port from rejection sampling, memory port from mask expansion
`timescale 1ns/1ps
`default_nettype none

module sampler_top
  import sampler_pkg::*;
#(
  parameter int N      = 256,
  parameter int ADDR_W = sampler_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  sampler_mode_e     sampler_mode_i,
  input  logic              sampler_start_i,
  input  logic [ADDR_W-1:0] dest_base_addr_i,
  input  logic              rand_valid_i,
  input  rand_word_t        rand_data_i,
  output logic              rand_hold_o,
  output logic              busy_o,
  output coeff_out_t        ntt_o,
  output mem_wr_t           mem_o
);

  logic        run;
  logic        clear;
  logic        piso_dv;
  logic        piso_hold;
  piso_chunk_t piso_data;
  logic        rej_dv;
  logic        rej_hold;
  logic        exp_dv;
  coeff_out_t  exp_out;

  sampler_ctrl #(
    .N      (N),
    .ADDR_W (ADDR_W)
  ) ctrl_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .sampler_mode_i   (sampler_mode_i),
    .sampler_start_i  (sampler_start_i),
    .dest_base_addr_i (dest_base_addr_i),
    .piso_dv_i        (piso_dv),
    .piso_hold_o      (piso_hold),
    .rej_dv_o         (rej_dv),
    .rej_hold_i       (rej_hold),
    .exp_dv_o         (exp_dv),
    .rej_out_i        (ntt_o),
    .exp_out_i        (exp_out),
    .run_o            (run),
    .clear_o          (clear),
    .busy_o           (busy_o),
    .mem_o            (mem_o)
  );

  sampler_piso piso_i (
    .clk            (clk),
    .rst_b          (rst_b),
    .clear_i        (clear),
    .run_i          (run),
    .sampler_mode_i (sampler_mode_i),
    .rand_valid_i   (rand_valid_i),
    .rand_data_i    (rand_data_i),
    .rand_hold_o    (rand_hold_o),
    .piso_dv_o      (piso_dv),
    .piso_hold_i    (piso_hold),
    .piso_data_o    (piso_data)
  );

  rej_sampler rej_i (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (clear),
    .valid_i (rej_dv),
    .hold_o  (rej_hold),
    .data_i  (piso_data),
    .out_o   (ntt_o)
  );

  exp_mask exp_i (
    .clk     (clk),
    .rst_b   (rst_b),
    .clear_i (clear),
    .valid_i (exp_dv),
    .data_i  (piso_data),
    .out_o   (exp_out)
  );

endmodule

`default_nettype wire

// File: hdl/sampler_ctrl.sv
// Sampler run control
//   IDLE/RUN/DONE FSM and group counter up to N/4
//   destination address for mask expansion writes
//   steers PISO valid/hold to the sampler of the active mode
`timescale 1ns/1ps
`default_nettype none

module sampler_ctrl
  import sampler_pkg::*;
#(
  parameter int N      = 256,
  parameter int ADDR_W = sampler_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  sampler_mode_e     sampler_mode_i,
  input  logic              sampler_start_i,
  input  logic [ADDR_W-1:0] dest_base_addr_i,
  input  logic              piso_dv_i,
  output logic              piso_hold_o,
  output logic              rej_dv_o,
  input  logic              rej_hold_i,
  output logic              exp_dv_o,
  input  coeff_out_t        rej_out_i,
  input  coeff_out_t        exp_out_i,
  output logic              run_o,
  output logic              clear_o,
  output logic              busy_o,
  output mem_wr_t           mem_o
);

  localparam int GROUPS = N / COEFF_PER_CLK;
  localparam int GCNT_W = $clog2(GROUPS + 1);

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    RUN  = 2'b01,
    DONE = 2'b10
  } ctrl_state_e;

  ctrl_state_e       state_q;
  ctrl_state_e       state_d;
  logic [GCNT_W-1:0] grp_cnt_q;
  logic [ADDR_W-1:0] dest_addr_q;
  logic              rej_mode;
  logic              active;
  logic              grp_dv;
  logic              last_grp;

  assign rej_mode = (sampler_mode_i == SAMPLER_REJ);
  assign run_o    = (state_q == RUN);
  assign active   = run_o && !zeroize_i;
  assign busy_o   = sampler_start_i || (state_q != IDLE);
  assign clear_o  = zeroize_i || (state_q == DONE);

  // only rej_sampler pushes back on the PISO
  assign rej_dv_o    = piso_dv_i && run_o && rej_mode;
  assign exp_dv_o    = piso_dv_i && run_o && !rej_mode;
  assign piso_hold_o = !run_o || (rej_mode && rej_hold_i);

  assign grp_dv   = active && (rej_mode ? rej_out_i.dv : exp_out_i.dv);
  assign last_grp = grp_dv && (grp_cnt_q == GCNT_W'(GROUPS - 1));

  always_comb begin
    mem_o.dv   = active && !rej_mode && exp_out_i.dv;
    mem_o.addr = dest_addr_q;
    mem_o.data = exp_out_i.data;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (sampler_start_i) state_d = RUN;
      RUN:  if (last_grp) state_d = DONE;
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q     <= IDLE;
      grp_cnt_q   <= '0;
      dest_addr_q <= '0;
    end else if (zeroize_i) begin
      state_q     <= IDLE;
      grp_cnt_q   <= '0;
      dest_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == IDLE) && sampler_start_i) begin
        grp_cnt_q   <= '0;
        dest_addr_q <= dest_base_addr_i;
      end else if (grp_dv) begin
        grp_cnt_q <= grp_cnt_q + 1'b1;
        // write address advances in mask mode only
        if (!rej_mode) dest_addr_q <= dest_addr_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/exp_mask.sv
// Mask expansion
//   four lanes computing (2^19 - r) mod q from 20-bit samples
//   one output register stage
`timescale 1ns/1ps
`default_nettype none

module exp_mask
  import sampler_pkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  logic        clear_i,
  input  logic        valid_i,
  input  piso_chunk_t data_i,
  output coeff_out_t  out_o
);

  typedef logic [Q_WIDTH:0] diff_t;

  diff_t [COEFF_PER_CLK-1:0] diff;
  coeff_grp_t                coeff_d;
  coeff_grp_t                data_q;
  logic                      dv_q;

  always_comb begin
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      diff[i] = diff_t'(GAMMA1) - diff_t'(data_i[i*EXP_SAMPLE_W +: EXP_SAMPLE_W]);
      // negative result wraps by adding q
      coeff_d[i] = diff[i][Q_WIDTH] ? coeff_t'(diff[i] + diff_t'(MLDSA_Q)) : coeff_t'(diff[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      dv_q <= 1'b0;
    end else if (clear_i) begin
      dv_q <= 1'b0;
    end else begin
      dv_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      data_q <= coeff_d;
    end
  end

  always_comb begin
    out_o.dv   = dv_q;
    out_o.data = data_q;
  end

endmodule

`default_nettype wire

// File: hdl/rej_sampler.sv
// Rejection sampler
//   four 24-bit candidates per chunk, masked to 23 bits
//   candidates below q kept in order in an 8-entry compaction buffer
//   oldest four leave as one group on the NTT port
`timescale 1ns/1ps
`default_nettype none

module rej_sampler
  import sampler_pkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  logic        clear_i,
  input  logic        valid_i,
  output logic        hold_o,
  input  piso_chunk_t data_i,
  output coeff_out_t  out_o
);

  localparam int DEPTH = 2 * COEFF_PER_CLK;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = $clog2(DEPTH);

  typedef logic [CNT_W-1:0] slot_cnt_t;

  coeff_t [DEPTH-1:0]         cbuf_q;
  coeff_t [DEPTH-1:0]         cbuf_d;
  coeff_t [DEPTH-1:0]         cbuf_base;
  coeff_t [COEFF_PER_CLK-1:0] cand;
  logic   [COEFF_PER_CLK-1:0] accept;
  slot_cnt_t                  cnt_q;
  slot_cnt_t                  wr_idx;
  logic                       take;
  logic                       pop;

  // fewer than four free slots
  assign hold_o = (cnt_q > slot_cnt_t'(COEFF_PER_CLK));
  assign pop    = (cnt_q >= slot_cnt_t'(COEFF_PER_CLK));
  assign take   = valid_i && !hold_o;

  always_comb begin
    out_o.dv   = pop && !clear_i;
    out_o.data = cbuf_q[COEFF_PER_CLK-1:0];
  end

  always_comb begin
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      cand[i]   = data_i[i*REJ_SAMPLE_W +: Q_WIDTH];
      accept[i] = take && (cand[i] < MLDSA_Q);
    end
  end

  // drop the outgoing group, then pack accepted candidates behind the rest
  always_comb begin
    cbuf_base = pop ? (cbuf_q >> (COEFF_PER_CLK * Q_WIDTH)) : cbuf_q;
    wr_idx    = pop ? (cnt_q - slot_cnt_t'(COEFF_PER_CLK)) : cnt_q;
    cbuf_d    = cbuf_base;
    for (int i = 0; i < COEFF_PER_CLK; i++) begin
      if (accept[i]) begin
        cbuf_d[wr_idx[IDX_W-1:0]] = cand[i];
        wr_idx = wr_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= wr_idx;
    end
  end

  always_ff @(posedge clk) begin
    cbuf_q <= cbuf_d;
  end

endmodule

`default_nettype wire

// File: hdl/sampler_piso.sv
// Bit-stream buffer between the random word source and the samplers
//   appends 64-bit words above the current fill level
//   emits 96-bit chunks in rejection mode, 80-bit chunks in mask mode
//   valid/hold on both sides
`timescale 1ns/1ps
`default_nettype none

module sampler_piso
  import sampler_pkg::*;
(
  input  logic          clk,
  input  logic          rst_b,
  input  logic          clear_i,
  input  logic          run_i,
  input  sampler_mode_e sampler_mode_i,
  input  logic          rand_valid_i,
  input  rand_word_t    rand_data_i,
  output logic          rand_hold_o,
  output logic          piso_dv_o,
  input  logic          piso_hold_i,
  output piso_chunk_t   piso_data_o
);

  localparam int BUF_W     = 192;
  localparam int CNT_W     = $clog2(BUF_W + 1);
  localparam int REJ_CHUNK = COEFF_PER_CLK * REJ_SAMPLE_W;
  localparam int EXP_CHUNK = COEFF_PER_CLK * EXP_SAMPLE_W;

  typedef logic [BUF_W-1:0] piso_buf_t;
  typedef logic [CNT_W-1:0] fill_t;

  piso_buf_t sbuf_q;
  piso_buf_t sbuf_d;
  piso_buf_t kept;
  piso_buf_t word_ext;
  fill_t     fill_q;
  fill_t     fill_d;
  fill_t     fill_kept;
  fill_t     chunk_w;
  logic      push;
  logic      pop;

  assign chunk_w = (sampler_mode_i == SAMPLER_REJ) ? fill_t'(REJ_CHUNK) : fill_t'(EXP_CHUNK);

  // room for one more word only while fill is 128 or less
  assign rand_hold_o = !run_i || (fill_q > fill_t'(BUF_W - RAND_W));

  assign piso_dv_o   = (fill_q >= chunk_w);
  assign piso_data_o = sbuf_q[REJ_CHUNK-1:0];

  assign push = rand_valid_i && !rand_hold_o;
  assign pop  = piso_dv_o && !piso_hold_i;

  always_comb begin
    kept      = pop ? (sbuf_q >> chunk_w) : sbuf_q;
    fill_kept = pop ? (fill_q - chunk_w) : fill_q;
    word_ext  = piso_buf_t'(rand_data_i);
    sbuf_d    = kept;
    fill_d    = fill_kept;
    if (push) begin
      // stale bits above the fill level are masked off before the append
      sbuf_d = (kept & ~({BUF_W{1'b1}} << fill_kept)) | (word_ext << fill_kept);
      fill_d = fill_kept + fill_t'(RAND_W);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fill_q <= '0;
    end else if (clear_i) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_d;
    end
  end

  // shift buffer contents
  always_ff @(posedge clk) begin
    sbuf_q <= sbuf_d;
  end

endmodule

`default_nettype wire

// File: hdl/sampler_pkg.sv
// Shared definitions for the coefficient sampler
//   modulus and sample width constants
//   vector typedefs for coefficients, input words and PISO chunks
//   sampling mode enum
//   output structs for the NTT port and the memory write port
`default_nettype none

package sampler_pkg;

  parameter int Q_WIDTH       = 23;
  parameter int RAND_W        = 64;
  parameter int REJ_SAMPLE_W  = 24;
  parameter int EXP_SAMPLE_W  = 20;
  parameter int COEFF_PER_CLK = 4;
  parameter int GAMMA1        = 524288;
  parameter int ADDR_W        = 8;

  typedef logic [Q_WIDTH-1:0] coeff_t;

  // q = 2^23 - 2^13 + 1
  parameter coeff_t MLDSA_Q = 23'd8380417;

  typedef coeff_t [COEFF_PER_CLK-1:0] coeff_grp_t;
  typedef logic [RAND_W-1:0] rand_word_t;

  // mask mode reads only the low 80 bits
  typedef logic [COEFF_PER_CLK*REJ_SAMPLE_W-1:0] piso_chunk_t;

  typedef enum logic {
    SAMPLER_REJ = 1'b0,
    SAMPLER_EXP = 1'b1
  } sampler_mode_e;

  typedef struct packed {
    logic       dv;
    coeff_grp_t data;
  } coeff_out_t;

  typedef struct packed {
    logic              dv;
    logic [ADDR_W-1:0] addr;
    coeff_grp_t        data;
  } mem_wr_t;

endpackage

`default_nettype wire
